// ==== addressDecode.sv ====
`include "amigaPciGlue_consts.svh"

module addressDecode (
  input  logic                          CLK40,
  input  logic                          RESETn,
  input  logic [31:12]                  addr,
  input  logic                          rnw,
  input  logic                          ovl,
  input  cpuBusPkg::transferType_t     tt,
  input  cpuBusPkg::transferModifier_t tm,
  input  logic                          ciaEnable,
  input  logic                          configured,
  input  logic [7:0]                    bridgeBase,
  input  logic [7:1]                    ideBase,
  input  logic [2:0]                    proBase,
  output logic                          romEn,
  output logic                          ciaSpace,
  output logic                          ciaCs0n,
  output logic                          ciaCs1n,
  output logic                          ramSpacen,
  output logic                          regSpacen,
  output logic                          flashSpace,
  output logic [1:0]                    flashBank,
  output logic                          autovector,
  output logic                          rtcEnn,
  output logic                          autoconfigSpace,
  output logic                          ataSpace,
  output logic                          ataEnn,
  output logic                          bregEnn,
  output logic                          bproEnn,
  output logic                          pcs0,
  output logic                          pcs1,
  output logic                          scs0,
  output logic                          scs1,
  output pciBridgePkg::pciAccess_t     pciAccess
);

  import cpuBusPkg::*;
  import pciBridgePkg::*;

  logic z2Space;
  logic ataEn;
  logic driveSel;
  logic cs0;
  logic cs1;
  logic proHit;
  logic altSpace;
  logic proConf0;
  logic proConf1;
  logic proIo;

  ////////////////////////////////////////////////////////////
  // Zorro 2 windows
  ////////////////////////////////////////////////////////////

  // Lowest 16 MB only, nothing decodes while in reset
  assign z2Space = RESETn && (addr[31:24] == 8'h00);

  // High ROM always, low ROM only while overlay is up
  assign romEn = z2Space &&
                 ((addr[23:19] == `ROM_HI_PREFIX) || (ovl && addr[23:19] == 5'b00000));

  // Chip RAM in the first 2 MB, hidden by the overlay
  assign ramSpacen = !(z2Space && !ovl && addr[23:21] == 3'b000);
  assign regSpacen = !(z2Space && addr[23:16] == `REG_PAGE);
  assign rtcEnn = !(z2Space && addr[23:17] == `RTC_PREFIX);
  assign autoconfigSpace = z2Space && (addr[23:16] == `AUTOCONFIG_PAGE);

  // CIA window, selects open only inside the E clock window
  assign ciaSpace = z2Space && (addr[23:16] == `CIA_PAGE);
  assign ciaCs0n = !(RESETn && ciaEnable && !addr[12]);
  assign ciaCs1n = !(RESETn && ciaEnable && !addr[13]);

  // Flash banks at $C8, $D0, $E0 and $F0, 512 KB each
  assign flashSpace = z2Space && (addr[23:22] == 2'b11) &&
                      (addr[21:19] == 3'b001 || addr[21:19] == 3'b010 ||
                       addr[21:19] == 3'b100 || addr[21:19] == 3'b110);
  assign flashBank = flashSpace ? addr[21:20] : 2'b00;

  // Interrupt acknowledge at the top 64 KB is always autovectored
  assign autovector = RESETn && (tt == ackAccess) && (addr[31:16] == 16'hFFFF);

  ////////////////////////////////////////////////////////////
  // ATA
  ////////////////////////////////////////////////////////////

  // 128 KB board at the IDE base
  assign ataSpace = z2Space && configured && (addr[23:17] == ideBase);

  // Boot ROM shows until the first write, then the drive registers
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      ataEn <= 1'b0;
    end else if (ataSpace && !rnw) begin
      ataEn <= 1'b1;
    end
  end

  assign ataEnn = !(ataSpace && ataEn);
  assign driveSel = ataSpace && ataEn;

  // Task file at CS0, control block at CS1
  // Bit 14 picks primary or secondary channel
  assign cs0 = !addr[16] && !addr[15] && !addr[13] && addr[12];
  assign cs1 = !addr[16] && !addr[15] && addr[13] && !addr[12];
  assign pcs0 = driveSel && !addr[14] && cs0;
  assign pcs1 = driveSel && addr[14] && cs0;
  assign scs0 = driveSel && !addr[14] && cs1;
  assign scs1 = driveSel && addr[14] && cs1;

  ////////////////////////////////////////////////////////////
  // PCI bridge
  ////////////////////////////////////////////////////////////

  // Bridge registers as a 64 KB Z2 board
  assign bregEnn = !(z2Space && configured && addr[23:16] == bridgeBase);

  // Prometheus style 512 MB Z3 window
  assign proHit = RESETn && configured && (addr[31:29] == proBase);
  assign bproEnn = !proHit;

  // Tags within the Prometheus window
  assign proConf0 = proHit && (addr[28:20] == `PRO_CONF0_TAG);
  assign proConf1 = proHit && (addr[28:20] == `PRO_CONF1_TAG);
  assign proIo = proHit && (addr[28:21] == `PRO_IO_TAG);
  assign altSpace = (tt == alternate);

  // Tags first, then alternate-space function codes
  always_comb begin
    if (!RESETn) begin
      pciAccess = pciConfig0;
    end else if (proConf0) begin
      pciAccess = pciConfig0;
    end else if (proConf1) begin
      pciAccess = pciConfig1;
    end else if (proIo) begin
      pciAccess = pciIo;
    end else if (altSpace && tm == conf0Mod) begin
      pciAccess = pciConfig0;
    end else if (altSpace && tm == conf1Mod) begin
      pciAccess = pciConfig1;
    end else begin
      pciAccess = pciMemory;
    end
  end

endmodule

// ==== amigaPciGlue.f ====
+incdir+.
cpuBusPkg.sv
pciBridgePkg.sv
addressDecode.sv
autoconfigRegs.sv
ciaCycleControl.sv
amigaPciGlue.sv
amigaPciGlue_assert.sv
tb_amigaPciGlue.sv

// ==== amigaPciGlue.sv ====
module amigaPciGlue (
  input  logic                          CLK40,
  input  logic                          RESETn,
  input  logic [31:1]                   addr,
  input  logic                          rnw,
  input  logic                          ts,
  input  cpuBusPkg::transferType_t     tt,
  input  cpuBusPkg::transferModifier_t tm,
  input  logic                          ovl,
  input  logic [7:0]                    dataHi,
  output logic                          romEn,
  output logic                          ciaSpace,
  output logic                          ciaCs0n,
  output logic                          ciaCs1n,
  output logic                          ramSpacen,
  output logic                          regSpacen,
  output logic                          flashSpace,
  output logic [1:0]                    flashBank,
  output logic                          autovector,
  output logic                          rtcEnn,
  output logic                          autoconfigSpace,
  output logic                          ataSpace,
  output logic                          ataEnn,
  output logic                          bregEnn,
  output logic                          bproEnn,
  output logic                          pcs0,
  output logic                          pcs1,
  output logic                          scs0,
  output logic                          scs1,
  output pciBridgePkg::pciAccess_t     pciAccess,
  output logic                          eClk,
  output logic                          ciaAck
);

  // Board placement from AutoConfig
  logic       configured;
  logic [7:0] bridgeBase;
  logic [7:1] ideBase;
  logic [2:0] proBase;
  // CIA window back into the decoder
  logic       ciaEnable;

  addressDecode addressDecode_inst (
    .CLK40(CLK40), .RESETn(RESETn), .addr(addr[31:12]), .rnw(rnw), .ovl(ovl),
    .tt(tt), .tm(tm), .ciaEnable(ciaEnable), .configured(configured),
    .bridgeBase(bridgeBase), .ideBase(ideBase), .proBase(proBase),
    .romEn(romEn), .ciaSpace(ciaSpace), .ciaCs0n(ciaCs0n), .ciaCs1n(ciaCs1n),
    .ramSpacen(ramSpacen), .regSpacen(regSpacen), .flashSpace(flashSpace),
    .flashBank(flashBank), .autovector(autovector), .rtcEnn(rtcEnn),
    .autoconfigSpace(autoconfigSpace), .ataSpace(ataSpace), .ataEnn(ataEnn),
    .bregEnn(bregEnn), .bproEnn(bproEnn), .pcs0(pcs0), .pcs1(pcs1),
    .scs0(scs0), .scs1(scs1), .pciAccess(pciAccess)
  );

  autoconfigRegs autoconfigRegs_inst (
    .CLK40(CLK40), .RESETn(RESETn), .ts(ts), .rnw(rnw),
    .autoconfigSpace(autoconfigSpace), .addrLow(addr[7:1]), .dataHi(dataHi),
    .configured(configured), .bridgeBase(bridgeBase), .ideBase(ideBase),
    .proBase(proBase)
  );

  ciaCycleControl ciaCycleControl_inst (
    .CLK40(CLK40), .RESETn(RESETn), .ts(ts), .ciaSpace(ciaSpace),
    .eClk(eClk), .ciaEnable(ciaEnable), .ciaAck(ciaAck)
  );

endmodule

// ==== amigaPciGlue_assert.sv ====
`include "amigaPciGlue_consts.svh"

module amigaPciGlueAssert (
  input logic                         CLK40,
  input logic                         RESETn,
  input logic [31:1]                  addr,
  input logic                         rnw,
  input logic                         ts,
  input logic                         ovl,
  input logic [7:0]                   dataHi,
  input cpuBusPkg::transferType_t     tt,
  input cpuBusPkg::transferModifier_t tm,
  input logic romEn, ciaSpace, ciaCs0n, ciaCs1n, ramSpacen, regSpacen,
  input logic flashSpace, autovector, rtcEnn, autoconfigSpace, ataSpace, ataEnn,
  input logic bregEnn, bproEnn, pcs0, pcs1, scs0, scs1,
  input logic [1:0]                   flashBank,
  input pciBridgePkg::pciAccess_t     pciAccess,
  input logic eClk, ciaAck, ciaEnable, configured
);

  timeunit 1ns;
  timeprecision 100ps;

  import cpuBusPkg::*;
  import pciBridgePkg::*;

  int unsigned errCount = 0;
  logic [31:0] byteAddr;
  logic        inZ2;
  logic        acWr;
  logic [1:0]  chainPos;
  logic        chainDone;
  logic [7:0]  bridgeAt;
  logic [6:0]  ideAt;
  logic [2:0]  proAt;
  logic        ideHit;
  logic        proHitExp;
  logic        ataOpen;
  logic [3:0]  driveSelExp;
  logic        ciaArmed;
  int          waitCycles;
  int          ePhase;
  pciAccess_t  accessExp;

  task automatic flagError(input string msg);
    errCount++;
    $error("%s", msg);
  endtask

  // Access code from tags first, then the alternate space function code
  function automatic pciAccess_t expectedAccess(logic [31:0] a, logic hit,
                                                transferType_t t, transferModifier_t m);
    if (hit && a[28:20] == `PRO_CONF0_TAG) return pciConfig0;
    if (hit && a[28:20] == `PRO_CONF1_TAG) return pciConfig1;
    if (hit && a[28:21] == `PRO_IO_TAG) return pciIo;
    if (t == alternate && m == conf0Mod) return pciConfig0;
    if (t == alternate && m == conf1Mod) return pciConfig1;
    return pciMemory;
  endfunction

  //////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////

  assign byteAddr = {addr, 1'b0};
  assign inZ2 = (byteAddr[31:24] == 8'h00);
  assign acWr = ts && !rnw && inZ2 && byteAddr[23:16] == `AUTOCONFIG_PAGE;
  assign chainDone = (chainPos == 2'd3);
  assign ideHit = inZ2 && chainDone && byteAddr[23:17] == ideAt;
  assign proHitExp = chainDone && byteAddr[31:29] == proAt;
  assign accessExp = expectedAccess(byteAddr, proHitExp, tt, tm);
  // Task file and control block of both channels
  assign driveSelExp = !(ideHit && ataOpen) ? 4'b0000 :
                       {byteAddr[16:12] == 5'b00001, byteAddr[16:12] == 5'b00101,
                        byteAddr[16:12] == 5'b00010, byteAddr[16:12] == 5'b00110};

  // Chain order bridge, IDE, Prometheus
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      chainPos <= 2'd0;
      bridgeAt <= 8'h00;
      ideAt <= 7'h00;
      proAt <= 3'b000;
      ataOpen <= 1'b0;
    end else begin
      if (acWr && chainPos == 2'd0 && byteAddr[7:0] == `AC_Z2_BASE_OFS) begin
        bridgeAt <= dataHi;
        chainPos <= 2'd1;
      end else if (acWr && chainPos == 2'd1 && byteAddr[7:0] == `AC_Z2_BASE_OFS) begin
        ideAt <= dataHi[7:1];
        chainPos <= 2'd2;
      end else if (acWr && chainPos == 2'd2 && byteAddr[7:0] == `AC_Z3_BASE_OFS) begin
        proAt <= dataHi[7:5];
        chainPos <= 2'd3;
      end
      if (ideHit && !rnw) begin
        ataOpen <= 1'b1;
      end
    end
  end

  // One armed request per CIA transfer start until the ack
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      ciaArmed <= 1'b0;
      waitCycles <= 0;
    end else if (ciaAck) begin
      ciaArmed <= 1'b0;
    end else if (ts && ciaSpace && !ciaArmed) begin
      ciaArmed <= 1'b1;
      waitCycles <= 0;
    end else begin
      waitCycles <= waitCycles + 1;
    end
  end

  // E clock phase, low phase first after reset
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      ePhase <= 0;
    end else begin
      ePhase <= (ePhase == `ECLK_PERIOD - 1) ? 0 : ePhase + 1;
    end
  end

  //////////////////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////////////////

  assert property (@(posedge CLK40) !RESETn |-> (!romEn && !ciaSpace && ciaCs0n && ciaCs1n
    && ramSpacen && regSpacen && !flashSpace && !autovector && rtcEnn && !autoconfigSpace
    && !ataSpace && ataEnn && bregEnn && bproEnn && !pcs0 && !pcs1 && !scs0 && !scs1))
    else flagError($sformatf("Decode output active during reset at %0t", $time));
  assert property (@(posedge CLK40) $rose(RESETn) |-> (!configured && !ciaEnable && !ciaAck))
    else flagError($sformatf("Register output not cleared by reset at %0t", $time));

  //////////////////////////////////////////////////////////////
  // Zorro 2 windows
  //////////////////////////////////////////////////////////////

  // ROM at the top 512 KB, or the bottom 512 KB under overlay
  assert property (@(posedge CLK40) disable iff (!RESETn) romEn == (inZ2 &&
    (byteAddr[23:19] == `ROM_HI_PREFIX || (ovl && byteAddr[23:19] == 5'b00000))))
    else flagError($sformatf("FAILED %0t romEn got %b expected %b", $time, romEn, !romEn));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    ramSpacen == !(inZ2 && !ovl && byteAddr[23:21] == 3'b000))
    else flagError($sformatf("FAILED %0t ramSpacen got %b expected %b", $time, ramSpacen,
                             !ramSpacen));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    regSpacen == !(inZ2 && byteAddr[23:16] == `REG_PAGE))
    else flagError($sformatf("FAILED %0t regSpacen got %b expected %b", $time, regSpacen,
                             !regSpacen));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    rtcEnn == !(inZ2 && byteAddr[23:17] == `RTC_PREFIX))
    else flagError($sformatf("FAILED %0t rtcEnn got %b expected %b", $time, rtcEnn, !rtcEnn));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    ciaSpace == (inZ2 && byteAddr[23:16] == `CIA_PAGE))
    else flagError($sformatf("FAILED %0t ciaSpace got %b expected %b", $time, ciaSpace,
                             !ciaSpace));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    autoconfigSpace == (inZ2 && byteAddr[23:16] == `AUTOCONFIG_PAGE))
    else flagError($sformatf("FAILED %0t autoconfigSpace got %b expected %b", $time,
                             autoconfigSpace, !autoconfigSpace));
  // Flash banks at $C8, $D0, $E0 and $F0, 512 KB each
  assert property (@(posedge CLK40) disable iff (!RESETn)
    flashSpace == (inZ2 && byteAddr[23:19] inside {5'h19, 5'h1A, 5'h1C, 5'h1E}))
    else flagError($sformatf("FAILED %0t flashSpace got %b expected %b", $time, flashSpace,
                             !flashSpace));
  // Bank select comes from bits 21:20
  assert property (@(posedge CLK40) disable iff (!RESETn)
    flashSpace |-> flashBank == byteAddr[21:20])
    else flagError($sformatf("FAILED %0t flashBank got %b expected %b", $time, flashBank,
                             byteAddr[21:20]));

  //////////////////////////////////////////////////////////////
  // AutoConfig, ATA and PCI
  //////////////////////////////////////////////////////////////

  assert property (@(posedge CLK40) disable iff (!RESETn) configured == chainDone)
    else flagError($sformatf("FAILED %0t configured got %b expected %b", $time, configured,
                             chainDone));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    bregEnn == !(inZ2 && chainDone && byteAddr[23:16] == bridgeAt))
    else flagError($sformatf("FAILED %0t bregEnn got %b expected %b", $time, bregEnn,
                             !bregEnn));
  assert property (@(posedge CLK40) disable iff (!RESETn) ataSpace == ideHit)
    else flagError($sformatf("FAILED %0t ataSpace got %b expected %b", $time, ataSpace,
                             ideHit));
  assert property (@(posedge CLK40) disable iff (!RESETn) bproEnn == !proHitExp)
    else flagError($sformatf("FAILED %0t bproEnn got %b expected %b", $time, bproEnn,
                             !proHitExp));
  // Drive registers only after the first write into IDE space
  assert property (@(posedge CLK40) disable iff (!RESETn) ataEnn == !(ideHit && ataOpen))
    else flagError($sformatf("FAILED %0t ataEnn got %b expected %b", $time, ataEnn,
                             !(ideHit && ataOpen)));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    {pcs0, pcs1, scs0, scs1} == driveSelExp)
    else flagError($sformatf("FAILED %0t pcs0,pcs1,scs0,scs1 got %b expected %b", $time,
                             {pcs0, pcs1, scs0, scs1}, driveSelExp));
  assert property (@(posedge CLK40) disable iff (!RESETn) pciAccess == accessExp)
    else flagError($sformatf("FAILED %0t pciAccess got %0d expected %0d", $time, pciAccess,
                             accessExp));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    autovector == (tt == ackAccess && byteAddr[31:16] == 16'hFFFF))
    else flagError($sformatf("FAILED %0t autovector got %b expected %b", $time, autovector,
                             !autovector));

  //////////////////////////////////////////////////////////////
  // CIA cycle
  //////////////////////////////////////////////////////////////

  // E clock low for the first part of each period, high for the last counts
  assert property (@(posedge CLK40) disable iff (!RESETn)
    eClk == (ePhase >= `ECLK_PERIOD - `ECLK_HIGH))
    else flagError($sformatf("FAILED %0t eClk got %b expected %b", $time, eClk, !eClk));
  assert property (@(posedge CLK40) disable iff (!RESETn) ciaEnable |-> eClk)
    else flagError($sformatf("CIA enable open outside E high at %0t", $time));
  // Window opens and closes with the E high phase
  assert property (@(posedge CLK40) disable iff (!RESETn) $rose(ciaEnable) |-> $rose(eClk))
    else flagError($sformatf("CIA enable did not open at the start of E high at %0t", $time));
  assert property (@(posedge CLK40) disable iff (!RESETn) $fell(ciaEnable) |-> $fell(eClk))
    else flagError($sformatf("CIA enable did not close at the end of E high at %0t", $time));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    {ciaCs0n, ciaCs1n} == {!(ciaEnable && !byteAddr[12]), !(ciaEnable && !byteAddr[13])})
    else flagError($sformatf("FAILED %0t ciaCs0n,ciaCs1n got %b expected %b", $time,
                             {ciaCs0n, ciaCs1n},
                             {!(ciaEnable && !byteAddr[12]), !(ciaEnable && !byteAddr[13])}));
  assert property (@(posedge CLK40) disable iff (!RESETn) ciaAck == $fell(ciaEnable))
    else flagError($sformatf("FAILED %0t ciaAck got %b expected %b", $time, ciaAck, !ciaAck));
  assert property (@(posedge CLK40) disable iff (!RESETn) $rose(ciaEnable) |-> ciaArmed)
    else flagError($sformatf("CIA window opened with no request at %0t", $time));
  assert property (@(posedge CLK40) disable iff (!RESETn)
    ciaArmed |-> waitCycles <= 2 * `ECLK_PERIOD)
    else flagError($sformatf("CIA request not acknowledged in two E periods at %0t", $time));

endmodule

bind amigaPciGlue amigaPciGlueAssert assertInst (.*);

// ==== amigaPciGlue_consts.svh ====
`ifndef AMIGA_PCI_GLUE_CONSTS_SVH
`define AMIGA_PCI_GLUE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Zorro 2 address windows
////////////////////////////////////////////////////////////

// Kickstart ROM at $F80000, compared on addr[23:19]
`define ROM_HI_PREFIX 5'b11111
// CIA page $BFxxxx, compared on addr[23:16]
`define CIA_PAGE 8'hBF
// Chipset registers $DFxxxx
`define REG_PAGE 8'hDF
// Zorro 2 AutoConfig page $E8xxxx
`define AUTOCONFIG_PAGE 8'hE8
// RTC at $DC0000 - $DDFFFF, compared on addr[23:17]
`define RTC_PREFIX 7'b1101110

// Prometheus tags inside the Z3 window
// Config tags compare on addr[28:20], I/O tag on addr[28:21]
`define PRO_CONF0_TAG 9'h1FC
`define PRO_CONF1_TAG 9'h1FD
`define PRO_IO_TAG 8'hFF

// AutoConfig base register byte offsets
`define AC_Z2_BASE_OFS 8'h48
`define AC_Z3_BASE_OFS 8'h44

// E clock, in CLK40 cycles
`define ECLK_PERIOD 56
`define ECLK_HIGH 24

`endif

// ==== autoconfigRegs.sv ====
`include "amigaPciGlue_consts.svh"

module autoconfigRegs (
  input  logic       CLK40,
  input  logic       RESETn,
  input  logic       ts,
  input  logic       rnw,
  input  logic       autoconfigSpace,
  input  logic [7:1] addrLow,
  input  logic [7:0] dataHi,
  output logic       configured,
  output logic [7:0] bridgeBase,
  output logic [7:1] ideBase,
  output logic [2:0] proBase
);

  import pciBridgePkg::*;

  acState_t acState;
  logic     acWrite;
  logic     z2BaseHit;
  logic     z3BaseHit;

  ////////////////////////////////////////////////////////////
  // Write qualification
  ////////////////////////////////////////////////////////////

  // A write is qualified by the transfer start
  assign acWrite = ts && !rnw && autoconfigSpace;

  // Byte offset rebuilt from the word address
  assign z2BaseHit = ({addrLow, 1'b0} == `AC_Z2_BASE_OFS);
  assign z3BaseHit = ({addrLow, 1'b0} == `AC_Z3_BASE_OFS);

  ////////////////////////////////////////////////////////////
  // Chain state machine
  ////////////////////////////////////////////////////////////

  // Only the board at the head of the chain answers
  // Once placed it drops out and the next one appears
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      acState <= acBridge;
      bridgeBase <= 8'h00;
      ideBase <= 7'h00;
      proBase <= 3'b000;
    end else if (acWrite) begin
      case (acState)
        acBridge: begin
          // 64 KB Z2 board takes the full byte of base
          if (z2BaseHit) begin
            bridgeBase <= dataHi;
            acState <= acIde;
          end
        end
        acIde: begin
          // 128 KB Z2 board
          if (z2BaseHit) begin
            ideBase <= dataHi[7:1];
            acState <= acPro;
          end
        end
        acPro: begin
          // 512 MB Z3 board takes its base from bits 7:5
          if (z3BaseHit) begin
            proBase <= dataHi[7:5];
            acState <= acDone;
          end
        end
        default: begin
          // Further writes fall through once the chain is complete
          acState <= acDone;
        end
      endcase
    end
  end

  // All three boards placed
  assign configured = (acState == acDone);

endmodule

// ==== ciaCycleControl.sv ====
`include "amigaPciGlue_consts.svh"

module ciaCycleControl (
  input  logic CLK40,
  input  logic RESETn,
  input  logic ts,
  input  logic ciaSpace,
  output logic eClk,
  output logic ciaEnable,
  output logic ciaAck
);

  localparam int lowPhaseLen = `ECLK_PERIOD - `ECLK_HIGH;

  logic [5:0] eCnt;
  logic       pending;
  logic       newReq;
  logic       enterHigh;
  logic       leaveHigh;

  ////////////////////////////////////////////////////////////
  // E clock divider
  ////////////////////////////////////////////////////////////

  // Low phase first, high phase in the last counts
  assign eClk = (eCnt >= 6'(lowPhaseLen));
  assign enterHigh = (eCnt == 6'(lowPhaseLen - 1));
  assign leaveHigh = (eCnt == 6'(`ECLK_PERIOD - 1));

  // Ignored while a request is waiting or running
  assign newReq = ts && ciaSpace && !pending && !ciaEnable;

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      eCnt <= 6'd0;
      pending <= 1'b0;
      ciaEnable <= 1'b0;
      ciaAck <= 1'b0;
    end else begin
      eCnt <= leaveHigh ? 6'd0 : eCnt + 6'd1;
      // Ack in the first low cycle after the window
      ciaAck <= ciaEnable && leaveHigh;
      if (enterHigh && (pending || newReq)) begin
        // Window covers the whole E high phase
        ciaEnable <= 1'b1;
        pending <= 1'b0;
      end else begin
        if (leaveHigh) begin
          ciaEnable <= 1'b0;
        end
        if (newReq) begin
          pending <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== cpuBusPkg.sv ====
package cpuBusPkg;

  // 68040 TT[1:0] transfer type
  typedef enum logic [1:0] {
    normal    = 2'b00,
    move16    = 2'b01,
    // Alternate function code space, used for PCI config cycles
    alternate = 2'b10,
    // Interrupt acknowledge
    ackAccess = 2'b11
  } transferType_t;

  // 68040 TM[2:0] transfer modifier
  // In alternate space these carry the function code
  typedef enum logic [2:0] {
    conf0Mod    = 3'd0,
    tmUserData  = 3'd1,
    tmUserCode  = 3'd2,
    conf1Mod    = 3'd3,
    tmTableCode = 3'd4,
    tmSuperData = 3'd5,
    tmSuperCode = 3'd6,
    tmReserved  = 3'd7
  } transferModifier_t;

endpackage

// ==== pciBridgePkg.sv ====
package pciBridgePkg;

  // Access type code handed to the PCI bridge
  typedef enum logic [1:0] {
    pciConfig0 = 2'b00,
    pciConfig1 = 2'b01,
    pciMemory  = 2'b10,
    // Legacy I/O, kept for Prometheus drivers
    pciIo      = 2'b11
  } pciAccess_t;

  // AutoConfig chain position
  // Boards are placed in this order
  typedef enum logic [1:0] {
    acBridge = 2'b00,
    acIde    = 2'b01,
    acPro    = 2'b10,
    acDone   = 2'b11
  } acState_t;

endpackage

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_amigaPciGlue \
  -f amigaPciGlue.f -o simAmigaPciGlue
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "Verilator build failed with status $buildStatus"
  exit 1
fi

# Keep running past the first assertion so the testbench reports the failure
simOutput=$(./obj_dir/simAmigaPciGlue +verilator+error+limit+100 2>&1)
runStatus=$?
echo "$simOutput"
if [ $runStatus -ne 0 ]; then
  echo "Simulator exited with status $runStatus"
fi

if echo "$simOutput" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

// ==== tb_amigaPciGlue.sv ====
`include "amigaPciGlue_consts.svh"

module tb_amigaPciGlue;

  timeunit 1ns;
  timeprecision 100ps;

  import cpuBusPkg::*;
  import pciBridgePkg::*;

  localparam int ciaTests = 3;
  localparam int randomCycles = 400;
  // Four E periods per CIA test, the random cycles and the directed part
  localparam int watchdogCycles = ciaTests * 4 * `ECLK_PERIOD + randomCycles + 300;

  logic              CLK40;
  logic              RESETn;
  logic [31:0]       byteAddr;
  logic              rnw;
  logic              ts;
  logic              ovl;
  logic [7:0]        dataHi;
  transferType_t     tt;
  transferModifier_t tm;
  logic romEn, ciaSpace, ciaCs0n, ciaCs1n, ramSpacen, regSpacen, flashSpace;
  logic autovector, rtcEnn, autoconfigSpace, ataSpace, ataEnn, bregEnn, bproEnn;
  logic pcs0, pcs1, scs0, scs1, eClk, ciaAck;
  logic [1:0]        flashBank;
  pciAccess_t        pciAccess;
  logic [31:0]       lcgState;

  amigaPciGlue amigaPciGlue_inst (.addr(byteAddr[31:1]), .*);

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // One bus cycle with ts and the write level for a single clock
  task automatic busCycle(input logic [31:0] a, input logic write, input transferType_t t,
                          input transferModifier_t m, input logic [7:0] d);
    @(posedge CLK40);
    byteAddr <= a;
    rnw <= !write;
    tt <= t;
    tm <= m;
    dataHi <= d;
    ts <= 1'b1;
    @(posedge CLK40);
    ts <= 1'b0;
    rnw <= 1'b1;
  endtask

  // Reads only with half of them forced into Z2 space
  task automatic randomAccesses(input int count);
    logic [31:0] r;
    logic [31:0] s;
    repeat (count) begin
      r = nextRandom();
      s = nextRandom();
      @(posedge CLK40);
      byteAddr <= r[7] ? {8'h00, s[23:0]} : s;
      ovl <= r[3];
      tt <= transferType_t'(r[9:8]);
      tm <= transferModifier_t'(r[12:10]);
    end
  endtask

  task automatic waitCiaAck();
    int waited;
    waited = 0;
    while (ciaAck !== 1'b1) begin
      @(posedge CLK40);
      #2;
      waited++;
      if (waited > 2 * `ECLK_PERIOD + 4) begin
        $display("No CIA acknowledge within two E clock periods");
        $display("Simulation FAILED");
        $fatal(1, "CIA cycle timed out");
      end
    end
  endtask

  initial begin
    CLK40 = 1'b0;
    forever #5 CLK40 = ~CLK40;
  end

  initial begin
    #(watchdogCycles * 10);
    $display("Watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $fatal(1, "Watchdog timeout");
  end

  // Any assertion failure ends the run
  always @(posedge CLK40) begin
    if (amigaPciGlue_inst.assertInst.errCount != 0) begin
      $display("Simulation FAILED");
      $fatal(1, "Assertion failure reported");
    end
  end

  initial begin
    lcgState = 32'd9;
    RESETn = 1'b0;
    byteAddr = 32'h0000_0000;
    rnw = 1'b1;
    ts = 1'b0;
    ovl = 1'b1;
    dataHi = 8'h00;
    tt = normal;
    tm = conf0Mod;
    repeat (3) @(posedge CLK40);
    RESETn <= 1'b1;

    // Windows and decode with no board placed yet
    randomAccesses(randomCycles / 2);
    // Accesses at the reset bases where no board may answer yet
    busCycle(32'h0000_0000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h0001_0000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h1FC0_0000, 1'b0, normal, tmSuperData, 8'h00);

    // Place bridge, IDE and Prometheus, then one stray write
    busCycle(32'h00E8_0048, 1'b1, normal, tmSuperData, 8'h40);
    busCycle(32'h00E8_0048, 1'b1, normal, tmSuperData, 8'hEA);
    busCycle(32'h00E8_0044, 1'b1, normal, tmSuperData, 8'h20);
    busCycle(32'h00E8_0048, 1'b1, normal, tmSuperData, 8'h77);
    busCycle(32'h0040_0000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h0041_0000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h2000_0000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h4000_0000, 1'b0, normal, tmSuperData, 8'h00);

    // ATA boot ROM, then the drive registers after the first write
    busCycle(32'h00EA_1000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h00EA_1000, 1'b1, normal, tmSuperData, 8'h00);
    busCycle(32'h00EA_1000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h00EA_5000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h00EA_2000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h00EA_6000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h00EB_0000, 1'b0, normal, tmSuperData, 8'h00);

    // PCI access types and autovector
    busCycle(32'h3FC0_0000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h3FD0_0000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h3FE0_0000, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h0000_1000, 1'b0, alternate, conf0Mod, 8'h00);
    busCycle(32'h0000_1000, 1'b0, alternate, conf1Mod, 8'h00);
    busCycle(32'h0000_1000, 1'b0, alternate, tmUserData, 8'h00);
    busCycle(32'hFFFF_0018, 1'b0, ackAccess, tmSuperData, 8'h00);
    busCycle(32'hFFFE_0018, 1'b0, ackAccess, tmSuperData, 8'h00);

    // CIA cycles with a second start while the third is pending
    busCycle(32'h00BF_E001, 1'b0, normal, tmSuperData, 8'h00);
    waitCiaAck();
    busCycle(32'h00BF_D000, 1'b1, normal, tmSuperData, 8'h00);
    waitCiaAck();
    busCycle(32'h00BF_E001, 1'b0, normal, tmSuperData, 8'h00);
    busCycle(32'h00BF_D000, 1'b0, normal, tmSuperData, 8'h00);
    waitCiaAck();

    randomAccesses(randomCycles / 2);
    repeat (2) @(posedge CLK40);
    if (amigaPciGlue_inst.assertInst.errCount == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "Assertion failures at end of run");
    end
  end

endmodule
